//--- design/hsk_byte_fifo.sv
`timescale 1ns/1ps

module hsk_byte_fifo #(
    parameter int DATA_DEPTH_QWORDS = 512
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    hsk_fifo_wr_if.fifo            wr,
    output hsk_spi_pkg::spi_byte_t rd_data,
    input  logic                   rd_en
);

    localparam int AW = $clog2(DATA_DEPTH_QWORDS);

    hsk_stream_pkg::qword_t mem [DATA_DEPTH_QWORDS];
    hsk_stream_pkg::qword_t head_word;
    // pointers carry one extra bit so that full and empty can be told apart
    logic [AW:0]            wr_ptr;
    logic [AW:0]            rd_ptr;
    logic [AW:0]            used;
    // byte within the head word, 0 is the top byte
    logic [2:0]             byte_sel;
    logic                   empty;

    // a word stays counted until its last byte has been read
    assign used    = wr_ptr - rd_ptr;
    assign empty   = (used == '0);
    // depth is a power of two, so only a full FIFO sets the top bit of the level
    assign wr.full = used[AW];
    assign wr.fill = hsk_stream_pkg::data_fill_t'(used);

    // show-ahead read: the current byte is always present at rd_data
    assign head_word = mem[rd_ptr[AW-1:0]];
    assign rd_data   = head_word[8*(7-byte_sel) +: 8];

    always_ff @(posedge aclk) begin
        if (wr.write) begin
            mem[wr_ptr[AW-1:0]] <= wr.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            byte_sel <= '0;
        end else begin
            if (wr.write) begin
                wr_ptr <= wr_ptr + (AW+1)'(1);
            end
            // step through the eight bytes, then move on to the next word
            if (rd_en && !empty) begin
                byte_sel <= byte_sel + 3'd1;
                if (byte_sel == 3'd7) begin
                    rd_ptr <= rd_ptr + (AW+1)'(1);
                end
            end
        end
    end

endmodule

//--- design/hsk_count_fifo.sv
`timescale 1ns/1ps

module hsk_count_fifo #(
    parameter int COUNT_DEPTH = 16
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  hsk_stream_pkg::qword_count_t wr_data,
    input  logic                         wr_en,
    output logic                         full,
    output hsk_stream_pkg::qword_count_t rd_data,
    output logic                         valid,
    input  logic                         rd_en
);

    localparam int CW = $clog2(COUNT_DEPTH);

    hsk_stream_pkg::qword_count_t mem [COUNT_DEPTH];
    logic [CW:0]                  wr_ptr;
    logic [CW:0]                  rd_ptr;
    logic [CW:0]                  used;

    assign used    = wr_ptr - rd_ptr;
    // top bit of the level is only set at exactly COUNT_DEPTH entries
    assign full    = used[CW];
    // the oldest packet length is shown without a read
    assign valid   = (used != '0);
    assign rd_data = mem[rd_ptr[CW-1:0]];

    always_ff @(posedge aclk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[CW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + (CW+1)'(1);
            end
            if (rd_en && valid) begin
                rd_ptr <= rd_ptr + (CW+1)'(1);
            end
        end
    end

endmodule

//--- design/hsk_fifo_wr_if.sv
`timescale 1ns/1ps

// write port of the data FIFO, shared by the admission stage and the byte FIFO
interface hsk_fifo_wr_if;

    // byte-swapped and keep-masked payload word
    hsk_stream_pkg::qword_t     data;
    // a word is written in every cycle this is high
    logic                       write;
    // FIFO cannot take another word
    logic                       full;
    // words still held, including a word that is partly read out
    hsk_stream_pkg::data_fill_t fill;

    // the admission stage pushes words and watches the space left
    modport admit (output data, output write, input full, input fill);

    // the FIFO accepts words and reports its level
    modport fifo (input data, input write, output full, output fill);

endinterface

//--- design/hsk_spi_pkg.sv
package hsk_spi_pkg;

    // one byte as it is shifted out on miso
    typedef logic [7:0] spi_byte_t;

    // position of the current bit within the byte being shifted
    typedef logic [2:0] bit_index_t;

    // bytes handed out of one packet; 511 words of 8 bytes fit in 12 bits
    typedef logic [11:0] byte_count_t;

endpackage

//--- design/hsk_spi_readout.sv
`timescale 1ns/1ps

module hsk_spi_readout (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         sclk,
    input  logic                         cs_b,
    output logic                         miso,
    output logic                         irq,
    output logic                         complete,
    input  hsk_stream_pkg::qword_count_t pkt_qwords,
    input  logic                         pkt_valid,
    output logic                         pkt_read,
    input  hsk_spi_pkg::spi_byte_t       byte_data,
    output logic                         byte_read
);

    // two flops against metastability, a third to see the edge
    logic                     sclk_meta;
    logic                     sclk_sync;
    logic                     sclk_prev;
    logic                     cs_meta;
    logic                     cs_sync;
    logic                     cs_prev;
    logic                     sclk_rise;
    logic                     cs_fall;
    // high from the chip select edge until the last byte is handed out
    logic                     reading;
    hsk_spi_pkg::spi_byte_t   shift_reg;
    hsk_spi_pkg::bit_index_t  bit_cnt;
    // bytes already taken from the data FIFO for this packet
    hsk_spi_pkg::byte_count_t bytes_loaded;
    hsk_spi_pkg::byte_count_t bytes_total;
    logic                     last_byte;

    assign sclk_rise   = sclk_sync & ~sclk_prev;
    assign cs_fall     = ~cs_sync & cs_prev;
    assign bytes_total = {pkt_qwords, 3'b000};
    assign last_byte   = (bytes_loaded == bytes_total);

    ////////////////////
    // shift register
    ////////////////////

    // miso is one stage behind the shift register, so the bit set up at the
    // chip select edge is still on the line after the first rising edge and
    // every later bit shows up right after its own rising edge
    always_ff @(posedge aclk) begin
        if (cs_fall) begin
            shift_reg <= byte_data;
        end else if (reading && sclk_rise) begin
            if (bit_cnt == 3'd7 && !last_byte) begin
                shift_reg <= byte_data;
            end else begin
                shift_reg <= {shift_reg[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sclk_meta    <= 1'b0;
            sclk_sync    <= 1'b0;
            sclk_prev    <= 1'b0;
            cs_meta      <= 1'b1;
            cs_sync      <= 1'b1;
            cs_prev      <= 1'b1;
            reading      <= 1'b0;
            bit_cnt      <= '0;
            bytes_loaded <= '0;
            miso         <= 1'b0;
            byte_read    <= 1'b0;
            pkt_read     <= 1'b0;
            irq          <= 1'b0;
            complete     <= 1'b0;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            cs_meta   <= cs_b;
            cs_sync   <= cs_meta;
            cs_prev   <= cs_sync;

            // both read strobes are single-cycle pulses
            byte_read <= 1'b0;
            pkt_read  <= 1'b0;

            // interrupt tracks the count FIFO and so drops one cycle after the pop
            irq <= pkt_valid;

            // complete holds until the host starts its next transfer
            if (cs_fall) begin
                complete <= 1'b0;
            end else if (pkt_read) begin
                complete <= 1'b1;
            end

            if (cs_sync) begin
                bit_cnt <= '0;
            end else if (reading && sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end

            ////////////////////
            // byte sequencing
            ////////////////////

            if (cs_fall) begin
                // a transfer with nothing waiting keeps miso low throughout
                reading      <= pkt_valid;
                bytes_loaded <= hsk_spi_pkg::byte_count_t'(1);
                byte_read    <= pkt_valid;
                miso         <= pkt_valid & byte_data[7];
            end else if (cs_sync) begin
                miso <= 1'b0;
            end else if (reading && sclk_rise) begin
                miso <= shift_reg[7];
                if (bit_cnt == 3'd7) begin
                    // the eighth rising edge ends a byte: fetch the next or end the packet
                    if (last_byte) begin
                        reading  <= 1'b0;
                        pkt_read <= 1'b1;
                    end else begin
                        bytes_loaded <= bytes_loaded + 12'd1;
                        byte_read    <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- design/hsk_stream_pkg.sv
package hsk_stream_pkg;

    // one 64-bit word of the UDP payload stream
    typedef logic [63:0] qword_t;

    // byte keeps of one payload word, bit i qualifies byte i
    typedef logic [7:0] keep_t;

    // UDP length field, which counts the payload plus the 8-byte UDP header
    typedef logic [15:0] udp_length_t;

    // words in one stored packet; a packet never holds more than 511 of them
    typedef logic [8:0] qword_count_t;

    // fill level of the data FIFO in words, wide enough to hold a full 512-deep FIFO
    typedef logic [9:0] data_fill_t;

    // admission FSM states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_STORE,
        RX_COMPLETE,
        RX_DUMP
    } rx_state_e;

    // largest packet that can be stored, in words
    localparam int unsigned MAX_QWORDS = 511;

endpackage

//--- design/turf_hsk_read.sv
`timescale 1ns/1ps

module turf_hsk_read #(
    parameter int DATA_DEPTH_QWORDS = 512,
    parameter int COUNT_DEPTH       = 16
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    // UDP header stream, the length field sits in the low 16 bits
    input  hsk_stream_pkg::qword_t hdr_tdata,
    input  logic                   hdr_tvalid,
    output logic                   hdr_tready,
    // UDP payload stream
    input  hsk_stream_pkg::qword_t data_tdata,
    input  hsk_stream_pkg::keep_t  data_tkeep,
    input  logic                   data_tvalid,
    input  logic                   data_tlast,
    output logic                   data_tready,
    // host serial link
    input  logic                   sclk,
    input  logic                   cs_b,
    output logic                   miso,
    output logic                   irq_o,
    output logic                   complete_o
);

    hsk_stream_pkg::qword_count_t count_data;
    logic                         count_write;
    logic                         count_full;
    hsk_stream_pkg::qword_count_t pkt_qwords;
    logic                         pkt_valid;
    logic                         pkt_read;
    hsk_spi_pkg::spi_byte_t       fifo_byte;
    logic                         byte_read;

    hsk_fifo_wr_if fifo_wr ();

    udp_rx_admit #(
        .DATA_DEPTH_QWORDS (DATA_DEPTH_QWORDS)
    ) u_admit (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .hdr_tdata   (hdr_tdata[15:0]),
        .hdr_tvalid  (hdr_tvalid),
        .hdr_tready  (hdr_tready),
        .data_tdata  (data_tdata),
        .data_tkeep  (data_tkeep),
        .data_tvalid (data_tvalid),
        .data_tlast  (data_tlast),
        .data_tready (data_tready),
        .fifo_wr     (fifo_wr.admit),
        .count_data  (count_data),
        .count_write (count_write),
        .count_full  (count_full)
    );

    hsk_byte_fifo #(
        .DATA_DEPTH_QWORDS (DATA_DEPTH_QWORDS)
    ) u_byte_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr      (fifo_wr.fifo),
        .rd_data (fifo_byte),
        .rd_en   (byte_read)
    );

    hsk_count_fifo #(
        .COUNT_DEPTH (COUNT_DEPTH)
    ) u_count_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr_data (count_data),
        .wr_en   (count_write),
        .full    (count_full),
        .rd_data (pkt_qwords),
        .valid   (pkt_valid),
        .rd_en   (pkt_read)
    );

    hsk_spi_readout u_readout (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .sclk       (sclk),
        .cs_b       (cs_b),
        .miso       (miso),
        .irq        (irq_o),
        .complete   (complete_o),
        .pkt_qwords (pkt_qwords),
        .pkt_valid  (pkt_valid),
        .pkt_read   (pkt_read),
        .byte_data  (fifo_byte),
        .byte_read  (byte_read)
    );

endmodule

//--- design/udp_rx_admit.sv
`timescale 1ns/1ps

module udp_rx_admit #(
    parameter int DATA_DEPTH_QWORDS = 512
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  hsk_stream_pkg::udp_length_t  hdr_tdata,
    input  logic                         hdr_tvalid,
    output logic                         hdr_tready,
    input  hsk_stream_pkg::qword_t       data_tdata,
    input  hsk_stream_pkg::keep_t        data_tkeep,
    input  logic                         data_tvalid,
    input  logic                         data_tlast,
    output logic                         data_tready,
    hsk_fifo_wr_if.admit                 fifo_wr,
    output hsk_stream_pkg::qword_count_t count_data,
    output logic                         count_write,
    input  logic                         count_full
);

    hsk_stream_pkg::rx_state_e    state;
    hsk_stream_pkg::qword_count_t word_count;
    hsk_stream_pkg::qword_t       swapped;
    logic [12:0]                  hdr_qwords;
    logic [12:0]                  free_qwords;
    logic                         too_long;
    logic                         no_room;
    logic                         dump_hdr;
    logic                         hdr_xfer;
    logic                         data_xfer;

    ////////////////////
    // admission check
    ////////////////////

    // the length field includes the 8-byte UDP header, so dropping the low
    // three bits rounds the payload up to whole words and never under-counts
    assign hdr_qwords  = hdr_tdata[15:3];
    assign free_qwords = 13'(DATA_DEPTH_QWORDS) - {3'b000, fifo_wr.fill};
    assign too_long    = hdr_qwords > 13'(hsk_stream_pkg::MAX_QWORDS);
    assign no_room     = free_qwords < hdr_qwords;
    // a full count FIFO could not record the packet, so it goes to the bin as well
    assign dump_hdr    = too_long | no_room | count_full;

    assign hdr_tready  = (state == hsk_stream_pkg::RX_IDLE);
    // back-pressure only while storing; a dumped packet drains at full rate
    assign data_tready = (state == hsk_stream_pkg::RX_DUMP) |
                         ((state == hsk_stream_pkg::RX_STORE) & ~fifo_wr.full);
    assign hdr_xfer    = hdr_tvalid & hdr_tready;
    assign data_xfer   = data_tvalid & data_tready;

    ////////////////////
    // byte swap
    ////////////////////

    // the byte FIFO hands out the top byte of a word first, while the first
    // packet byte sits at the bottom of tdata, so the byte order is reversed
    // on the way in and bytes without a keep are pushed as zero
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            swapped[8*(7-i) +: 8] = data_tdata[8*i +: 8] & {8{data_tkeep[i]}};
        end
    end

    assign fifo_wr.data  = swapped;
    assign fifo_wr.write = (state == hsk_stream_pkg::RX_STORE) & data_tvalid & ~fifo_wr.full;

    // the word count is final in the complete state
    assign count_data  = word_count;
    assign count_write = (state == hsk_stream_pkg::RX_COMPLETE);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= hsk_stream_pkg::RX_IDLE;
            word_count <= '0;
        end else begin
            case (state)
                hsk_stream_pkg::RX_IDLE: begin
                    if (hdr_xfer) begin
                        state <= dump_hdr ? hsk_stream_pkg::RX_DUMP : hsk_stream_pkg::RX_STORE;
                    end
                end
                hsk_stream_pkg::RX_STORE: begin
                    if (data_xfer && data_tlast) begin
                        state <= hsk_stream_pkg::RX_COMPLETE;
                    end
                end
                // one cycle to push the word count, then back to waiting for a header
                hsk_stream_pkg::RX_COMPLETE: state <= hsk_stream_pkg::RX_IDLE;
                hsk_stream_pkg::RX_DUMP: begin
                    if (data_xfer && data_tlast) begin
                        state <= hsk_stream_pkg::RX_IDLE;
                    end
                end
                default: state <= hsk_stream_pkg::RX_IDLE;
            endcase

            // restart the count for every packet, only stored words are counted
            if (state == hsk_stream_pkg::RX_IDLE) begin
                word_count <= '0;
            end else if (state == hsk_stream_pkg::RX_STORE && data_xfer) begin
                word_count <= word_count + 9'd1;
            end
        end
    end

endmodule

//--- list.f
design/hsk_stream_pkg.sv
design/hsk_spi_pkg.sv
design/hsk_fifo_wr_if.sv
design/udp_rx_admit.sv
design/hsk_byte_fifo.sv
design/hsk_count_fifo.sv
design/hsk_spi_readout.sv
design/turf_hsk_read.sv
verif/turf_hsk_read_assertions.sv
verif/tb_turf_hsk_read.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_turf_hsk_read -f list.f

status=0
./obj_dir/Vtb_turf_hsk_read > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- verif/hsk_testdata.txt
// payload length in bytes (hex), first payload byte (hex), 1 if the packet is stored
// payload byte i is the first byte plus i, wrapped to 8 bits
001b 10 1
1000 33 0
0028 f0 1
0001 7e 1
0045 00 1
0ff8 81 0
0ff0 44 0
0010 55 1
000f a0 1

//--- verif/tb_turf_hsk_read.sv
`timescale 1ns/1ps

module tb_turf_hsk_read;

    localparam int MAX_PACKETS = 16;
    // the host holds each serial clock level for this many aclk cycles
    localparam int SCLK_HALF   = 5;
    // chip select has to pass two synchronizer flops and the edge detector
    localparam int CS_SETUP    = 6;
    localparam int READY_LIMIT = 200;
    localparam int IRQ_LIMIT   = 20;
    localparam int FLAG_LIMIT  = 40;

    // conditions that the wait loop can watch
    localparam int W_HDR_READY     = 0;
    localparam int W_DATA_READY    = 1;
    localparam int W_IRQ_HIGH      = 2;
    localparam int W_COMPLETE_HIGH = 3;
    localparam int W_COMPLETE_LOW  = 4;

    logic                   aclk;
    logic                   aresetn;
    hsk_stream_pkg::qword_t hdr_tdata;
    logic                   hdr_tvalid;
    logic                   hdr_tready;
    hsk_stream_pkg::qword_t data_tdata;
    hsk_stream_pkg::keep_t  data_tkeep;
    logic                   data_tvalid;
    logic                   data_tlast;
    logic                   data_tready;
    logic                   sclk;
    logic                   cs_b;
    logic                   miso;
    logic                   irq_o;
    logic                   complete_o;

    // three words per packet: payload length, first byte, stored flag
    logic [15:0] testdata [0:3*MAX_PACKETS-1];
    int          num_packets;
    // packets the DUT should hold, oldest first
    int          exp_len [$];
    int          exp_first [$];
    int          seed;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    logic        run_aborted;

    turf_hsk_read #(
        .DATA_DEPTH_QWORDS (512),
        .COUNT_DEPTH       (16)
    ) u_turf_hsk_read (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .hdr_tdata   (hdr_tdata),
        .hdr_tvalid  (hdr_tvalid),
        .hdr_tready  (hdr_tready),
        .data_tdata  (data_tdata),
        .data_tkeep  (data_tkeep),
        .data_tvalid (data_tvalid),
        .data_tlast  (data_tlast),
        .data_tready (data_tready),
        .sclk        (sclk),
        .cs_b        (cs_b),
        .miso        (miso),
        .irq_o       (irq_o),
        .complete_o  (complete_o)
    );

    always #5 aclk = ~aclk;

    ////////////////////
    // checking
    ////////////////////

    task automatic compare_byte(input hsk_spi_pkg::spi_byte_t got,
                                input hsk_spi_pkg::spi_byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s read as %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic verify_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // payload byte j counts up from the first byte, and the rest of the last word is zero
    function automatic hsk_spi_pkg::spi_byte_t expected_byte(input int len, input int first,
                                                            input int j);
        if (j < len) begin
            return hsk_spi_pkg::spi_byte_t'((first + j) % 256);
        end
        return '0;
    endfunction

    function automatic logic condition_met(input int which);
        case (which)
            W_HDR_READY:     return hdr_tready;
            W_DATA_READY:    return data_tready;
            W_IRQ_HIGH:      return irq_o;
            W_COMPLETE_HIGH: return complete_o;
            default:         return !complete_o;
        endcase
    endfunction

    // a timeout stops every later wait, so the run falls through to the summary
    task automatic wait_for(input int which, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!condition_met(which) && !run_aborted) begin
            @(negedge aclk);
            cycles++;
            if (cycles >= limit && !condition_met(which)) begin
                $display("timeout at %0t ns: gave up waiting for %s after %0d cycles",
                         $time, what, limit);
                errors++;
                run_aborted = 1'b1;
            end
        end
    endtask

    ////////////////////
    // stream side
    ////////////////////

    // byte i of the payload goes to lane i mod 8, lanes past the end carry filler
    // that the DUT must store as zero because their keep is low
    task automatic send_packet(input int len, input int first, input logic stored);
        hsk_stream_pkg::qword_t word;
        hsk_stream_pkg::keep_t  keep;
        int                     nbeats;
        int                     idx;
        logic                   irq_seen;
        if (run_aborted) return;
        nbeats     = (len + 7) / 8;
        hdr_tdata  = hsk_stream_pkg::qword_t'(len + 8);
        hdr_tvalid = 1'b1;
        wait_for(W_HDR_READY, READY_LIMIT, "header ready");
        // ready was high at this falling edge, so the next rising edge takes the header
        @(negedge aclk);
        hdr_tvalid = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            // valid drops now and then between beats, never while a beat waits
            if (($random(seed) & 3) == 0) begin
                data_tvalid = 1'b0;
                @(negedge aclk);
            end
            for (int k = 0; k < 8; k++) begin
                idx            = 8 * b + k;
                keep[k]        = (idx < len);
                word[8*k +: 8] = (idx < len) ? 8'((first + idx) % 256) : 8'hc3;
            end
            data_tdata  = word;
            data_tkeep  = keep;
            data_tlast  = (b == nbeats - 1);
            data_tvalid = 1'b1;
            wait_for(W_DATA_READY, READY_LIMIT, "data ready");
            @(negedge aclk);
        end
        data_tvalid = 1'b0;
        data_tlast  = 1'b0;
        // the FSM is back in idle once it offers to take a header again
        wait_for(W_HDR_READY, READY_LIMIT, "header ready after the last beat");
        if (stored) begin
            exp_len.push_back(len);
            exp_first.push_back(first);
            wait_for(W_IRQ_HIGH, IRQ_LIMIT, "irq_o after a stored packet");
        end else if (exp_len.size() == 0) begin
            irq_seen = 1'b0;
            repeat (6) begin
                @(negedge aclk);
                irq_seen = irq_seen | irq_o;
            end
            verify_flag(irq_seen, 1'b0, "irq_o after a dumped packet");
        end
    endtask

    task automatic send_line(input int i);
        send_packet(int'(testdata[3*i]), int'(testdata[3*i+1]), testdata[3*i+2][0]);
    endtask

    ////////////////////
    // serial side
    ////////////////////

    // one serial clock period, the bit is taken as sclk falls
    task automatic clock_bit(output logic bit_seen);
        sclk = 1'b1;
        repeat (SCLK_HALF) @(negedge aclk);
        sclk     = 1'b0;
        bit_seen = miso;
        repeat (SCLK_HALF) @(negedge aclk);
    endtask

    task automatic read_packet(input int len, input int first);
        hsk_spi_pkg::spi_byte_t got;
        int                     nbytes;
        // whole words come out, so a short last word is padded to 8 bytes
        nbytes = 8 * ((len + 7) / 8);
        cs_b   = 1'b0;
        repeat (CS_SETUP) @(negedge aclk);
        for (int j = 0; j < nbytes; j++) begin
            // MSB first
            for (int b = 7; b >= 0; b--) begin
                clock_bit(got[b]);
            end
            compare_byte(got, expected_byte(len, first, j),
                         $sformatf("byte %0d of a %0d-byte packet", j, len));
        end
        wait_for(W_COMPLETE_HIGH, FLAG_LIMIT, "complete_o after the readout");
        cs_b = 1'b1;
        repeat (SCLK_HALF) @(negedge aclk);
    endtask

    task automatic drain_packets();
        int len;
        int first;
        while (exp_len.size() != 0 && !run_aborted) begin
            verify_flag(irq_o, 1'b1, "irq_o while a packet waits");
            len   = exp_len.pop_front();
            first = exp_first.pop_front();
            read_packet(len, first);
            // interrupt stays up as long as something is still queued
            verify_flag(irq_o, exp_len.size() != 0, "irq_o after a readout");
        end
    endtask

    task automatic empty_readout();
        logic miso_seen;
        logic bit_seen;
        miso_seen = 1'b0;
        cs_b      = 1'b0;
        repeat (CS_SETUP) @(negedge aclk);
        repeat (64) begin
            clock_bit(bit_seen);
            miso_seen = miso_seen | bit_seen;
        end
        verify_flag(miso_seen, 1'b0, "miso during a readout with no packet");
        verify_flag(complete_o, 1'b0, "complete_o after a readout with no packet");
        cs_b = 1'b1;
        repeat (SCLK_HALF) @(negedge aclk);
    endtask

    task automatic load_testdata();
        // unused entries keep this marker, which ends the packet list
        for (int i = 0; i < 3 * MAX_PACKETS; i++) begin
            testdata[i] = 16'hffff;
        end
        $readmemh("verif/hsk_testdata.txt", testdata);
        num_packets = 0;
        while (num_packets < MAX_PACKETS && testdata[3*num_packets] != 16'hffff) begin
            num_packets++;
        end
        if (num_packets < 4) begin
            errors++;
            run_aborted = 1'b1;
            $display("test data file holds %0d packets, at least 4 are needed", num_packets);
        end
    endtask

    task automatic finish_test(input int number, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", number, name, errors - errors_at_start);
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        $timeformat(-9, 0, "", 0);
        aclk        = 1'b0;
        aresetn     = 1'b0;
        hdr_tdata   = '0;
        hdr_tvalid  = 1'b0;
        data_tdata  = '0;
        data_tkeep  = '0;
        data_tvalid = 1'b0;
        data_tlast  = 1'b0;
        sclk        = 1'b0;
        cs_b        = 1'b1;
        seed         = 12388;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        run_aborted  = 1'b0;
        load_testdata();

        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        errors_at_start = errors;
        verify_flag(irq_o, 1'b0, "irq_o after reset");
        verify_flag(complete_o, 1'b0, "complete_o after reset");
        verify_flag(hdr_tready, 1'b1, "header ready after reset");
        verify_flag(data_tready, 1'b0, "data ready after reset");
        finish_test(1, "reset");

        // first line of the file is a single packet that fits
        errors_at_start = errors;
        send_line(0);
        drain_packets();
        finish_test(2, "stored packet");

        errors_at_start = errors;
        if (!run_aborted) begin
            verify_flag(complete_o, 1'b1, "complete_o before the next chip select");
            cs_b = 1'b0;
            wait_for(W_COMPLETE_LOW, FLAG_LIMIT, "complete_o to clear");
            cs_b = 1'b1;
            repeat (SCLK_HALF) @(negedge aclk);
        end
        finish_test(3, "complete clears on chip select");

        // an oversized packet followed by one that fits
        errors_at_start = errors;
        send_line(1);
        send_line(2);
        drain_packets();
        finish_test(4, "oversized packet");

        // everything else is queued up before the host reads any of it
        errors_at_start = errors;
        for (int i = 3; i < num_packets; i++) begin
            send_line(i);
        end
        drain_packets();
        finish_test(5, "queued packets");

        errors_at_start = errors;
        if (!run_aborted) begin
            verify_flag(irq_o, 1'b0, "irq_o with nothing queued");
            empty_readout();
        end
        finish_test(6, "readout with no packet");

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && !run_aborted) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verif/turf_hsk_read_assertions.sv
`timescale 1ns/1ps

module turf_hsk_read_assertions (
    input logic aclk,
    input logic aresetn,
    input logic hdr_tready,
    input logic data_tready,
    input logic irq_o,
    input logic complete_o,
    input logic count_write,
    input logic pkt_read
);

    // packets held in the count FIFO, rebuilt from its write and pop pulses
    logic [5:0] pkts_held;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pkts_held <= '0;
        end else if (count_write && !pkt_read) begin
            pkts_held <= pkts_held + 6'd1;
        end else if (pkt_read && !count_write) begin
            pkts_held <= pkts_held - 6'd1;
        end
    end

    // the header is only taken in idle and payload never is
    header_data_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
        !(hdr_tready && data_tready))
        else $error("header ready and data ready are high in the same cycle");

    complete_low_after_reset: assert property (@(posedge aclk)
        !aresetn |=> !complete_o)
        else $error("complete_o is high right after reset");

    // a write shows at the FIFO valid one cycle later and at irq one more cycle
    // after that, so irq lines up with the packet count of two edges back
    irq_needs_packet: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(pkts_held) == 6'd0 |-> !irq_o)
        else $error("irq_o is high while the count FIFO is empty");

endmodule

bind turf_hsk_read turf_hsk_read_assertions u_assertions (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .hdr_tready  (hdr_tready),
    .data_tready (data_tready),
    .irq_o       (irq_o),
    .complete_o  (complete_o),
    .count_write (count_write),
    .pkt_read    (pkt_read)
);
